// File: design/desc_dma_sequencer.sv
`default_nettype none
`timescale 1ns/100ps

module desc_dma_sequencer #(
	parameter int LOCAL_DESC_NUM = 256,
	localparam int IDX_W = $clog2(LOCAL_DESC_NUM)
) (
	input wire aclk,
	input wire aresetn,
	input wire en,
	input wire tx_desc_pkg::host_addr_t tdba,
	input wire dpp,
	input wire tx_desc_pkg::thresh_t pthresh,
	input wire tx_desc_pkg::thresh_t hthresh,
	input wire tx_desc_pkg::ring_idx_t host_head,
	input wire tx_desc_pkg::ring_idx_t host_curr,
	input wire tx_desc_pkg::ring_idx_t host_fresh,
	input wire tx_desc_pkg::ring_idx_t host_limit,
	input wire [IDX_W:0] out_count,
	input wire [IDX_W:0] local_pending,
	input wire [IDX_W:0] local_available,
	input wire head_rs,
	input wire [IDX_W-1:0] in_tail_idx,
	input wire [IDX_W-1:0] out_head_idx,
	input wire idma_ready,
	input wire idma_done,
	input wire odma_ready,
	input wire odma_done,
	output tx_desc_pkg::host_addr_t idma_src_addr,
	output tx_desc_pkg::local_addr_t idma_dst_addr,
	output tx_desc_pkg::dma_bytes_t idma_bytes,
	output logic idma_valid,
	output tx_desc_pkg::local_addr_t odma_src_addr,
	output tx_desc_pkg::host_addr_t odma_dst_addr,
	output tx_desc_pkg::dma_bytes_t odma_bytes,
	output logic odma_valid,
	output logic host_forward,
	output tx_desc_pkg::ring_idx_t host_fwd_num,
	output logic in_enqueue,
	output tx_desc_pkg::ring_idx_t in_enq_num,
	output logic wb_dequeue,
	output logic txdw_req
);

	localparam int SETTLE_W = $clog2(tx_desc_pkg::SETTLE_CYCLES);

	tx_desc_pkg::fetch_state_t state;
	logic [SETTLE_W-1:0] settle_cnt;
	tx_desc_pkg::ring_idx_t avail_w, size_min, fetch_size;
	tx_desc_pkg::host_addr_t rd_host_addr, wb_host_addr;
	tx_desc_pkg::local_addr_t rd_local_addr, wb_local_addr;
	logic fetch_go;

	assign avail_w = tx_desc_pkg::ring_idx_t'(local_available);
	assign host_fwd_num = in_enq_num;

	assign rd_host_addr = tdba + (tx_desc_pkg::host_addr_t'(host_curr) << tx_desc_pkg::DESC_SHIFT);
	assign wb_host_addr = tdba + (tx_desc_pkg::host_addr_t'(host_head) << tx_desc_pkg::DESC_SHIFT)
		+ tx_desc_pkg::host_addr_t'(tx_desc_pkg::STA_OFFSET);
	assign rd_local_addr = tx_desc_pkg::local_addr_t'(in_tail_idx) << tx_desc_pkg::DESC_SHIFT;
	assign wb_local_addr = (tx_desc_pkg::local_addr_t'(out_head_idx) << tx_desc_pkg::DESC_SHIFT)
		+ tx_desc_pkg::local_addr_t'(tx_desc_pkg::STA_OFFSET);

	// Prefetch when the local store runs low, or always when it is empty
	assign fetch_go = (!dpp && (pthresh == '0 || local_pending < pthresh) && host_fresh > hthresh)
		|| local_pending == '0;

	// Smallest of ring end, fresh count and local room
	always_comb begin
		size_min = host_limit;
		if (host_fresh < size_min)
			size_min = host_fresh;
		if (avail_w < size_min)
			size_min = avail_w;
		fetch_size = (dpp && size_min > 1) ? tx_desc_pkg::ring_idx_t'(1) : size_min;
	end

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			state <= tx_desc_pkg::fs_idle;
			settle_cnt <= '0;
			idma_valid <= 1'b0;
			odma_valid <= 1'b0;
			in_enqueue <= 1'b0;
			host_forward <= 1'b0;
			wb_dequeue <= 1'b0;
			txdw_req <= 1'b0;
		end else begin
			in_enqueue <= 1'b0;
			host_forward <= 1'b0;
			wb_dequeue <= 1'b0;
			txdw_req <= 1'b0;
			case (state)
				tx_desc_pkg::fs_idle: begin
					if (en)
						state <= tx_desc_pkg::fs_ready;
				end
				tx_desc_pkg::fs_ready: begin
					if (!en) begin
						state <= tx_desc_pkg::fs_idle;
					end else if (out_count != '0) begin
						// Finished descriptors take priority over fetching
						if (head_rs) begin
							odma_valid <= 1'b1;
							state <= tx_desc_pkg::fs_wb_cmd;
						end else begin
							wb_dequeue <= 1'b1;
							state <= tx_desc_pkg::fs_dequeue;
						end
					end else if (fetch_go) begin
						state <= tx_desc_pkg::fs_set_size;
					end
				end
				tx_desc_pkg::fs_set_size: begin
					if (fetch_size == '0) begin
						state <= tx_desc_pkg::fs_ready;
					end else begin
						idma_valid <= 1'b1;
						state <= tx_desc_pkg::fs_fetch_cmd;
					end
				end
				tx_desc_pkg::fs_fetch_cmd: begin
					if (idma_ready) begin
						idma_valid <= 1'b0;
						state <= tx_desc_pkg::fs_fetch_wait;
					end
				end
				tx_desc_pkg::fs_fetch_wait: begin
					if (idma_done) begin
						in_enqueue <= 1'b1;
						host_forward <= 1'b1;
						state <= tx_desc_pkg::fs_enqueue;
					end
				end
				tx_desc_pkg::fs_wb_cmd: begin
					if (odma_ready) begin
						odma_valid <= 1'b0;
						state <= tx_desc_pkg::fs_wb_wait;
					end
				end
				tx_desc_pkg::fs_wb_wait: begin
					if (odma_done) begin
						wb_dequeue <= 1'b1;
						txdw_req <= 1'b1;
						state <= tx_desc_pkg::fs_dequeue;
					end
				end
				tx_desc_pkg::fs_enqueue, tx_desc_pkg::fs_dequeue: begin
					settle_cnt <= SETTLE_W'(tx_desc_pkg::SETTLE_CYCLES - 1);
					state <= tx_desc_pkg::fs_settle;
				end
				tx_desc_pkg::fs_settle: begin
					// Let the tracker pipeline and queue counts catch up
					if (settle_cnt == '0)
						state <= tx_desc_pkg::fs_ready;
					else
						settle_cnt <= settle_cnt - 1'b1;
				end
				default: state <= tx_desc_pkg::fs_idle;
			endcase
		end
	end

	// Command fields, stable while valid is high
	always_ff @(posedge aclk) begin
		if (state == tx_desc_pkg::fs_set_size) begin
			in_enq_num <= fetch_size;
			idma_src_addr <= rd_host_addr;
			idma_dst_addr <= rd_local_addr;
			idma_bytes <= tx_desc_pkg::dma_bytes_t'(fetch_size) << tx_desc_pkg::DESC_SHIFT;
		end
		if (state == tx_desc_pkg::fs_ready) begin
			odma_src_addr <= wb_local_addr;
			odma_dst_addr <= wb_host_addr;
			odma_bytes <= tx_desc_pkg::dma_bytes_t'(1);
		end
	end

endmodule

`default_nettype wire

// File: design/engine_dispatch.sv
`default_nettype none
`timescale 1ns/100ps

module engine_dispatch #(
	parameter int LOCAL_DESC_NUM = 256,
	localparam int IDX_W = $clog2(LOCAL_DESC_NUM)
) (
	input wire aclk,
	input wire aresetn,
	input wire en,
	input wire [IDX_W:0] in_count,
	input wire [IDX_W-1:0] in_head_idx,
	input wire teng_cmd_ready,
	input wire teng_rsp_valid,
	input wire teng_rsp_rs,
	output tx_desc_pkg::local_addr_t teng_cmd_addr,
	output logic teng_cmd_valid,
	output logic teng_rsp_ready,
	output logic in_dequeue,
	output logic out_enqueue,
	output logic out_rs
);

	tx_desc_pkg::dispatch_state_t state;

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			state <= tx_desc_pkg::ds_idle;
			teng_cmd_valid <= 1'b0;
			teng_rsp_ready <= 1'b0;
			in_dequeue <= 1'b0;
			out_enqueue <= 1'b0;
		end else begin
			in_dequeue <= 1'b0;
			out_enqueue <= 1'b0;
			case (state)
				tx_desc_pkg::ds_idle: begin
					if (en)
						state <= tx_desc_pkg::ds_ready;
				end
				tx_desc_pkg::ds_ready: begin
					if (!en) begin
						state <= tx_desc_pkg::ds_idle;
					end else if (in_count != '0) begin
						teng_cmd_valid <= 1'b1;
						state <= tx_desc_pkg::ds_cmd;
					end
				end
				tx_desc_pkg::ds_cmd: begin
					if (teng_cmd_ready) begin
						teng_cmd_valid <= 1'b0;
						in_dequeue <= 1'b1;
						state <= tx_desc_pkg::ds_dequeue;
					end
				end
				tx_desc_pkg::ds_dequeue: begin
					teng_rsp_ready <= 1'b1;
					state <= tx_desc_pkg::ds_wait_resp;
				end
				tx_desc_pkg::ds_wait_resp: begin
					// Single descriptor in flight, so the response belongs to it
					if (teng_rsp_valid) begin
						teng_rsp_ready <= 1'b0;
						out_enqueue <= 1'b1;
						state <= tx_desc_pkg::ds_enqueue;
					end
				end
				tx_desc_pkg::ds_enqueue: state <= tx_desc_pkg::ds_ready;
				default: state <= tx_desc_pkg::ds_idle;
			endcase
		end
	end

	always_ff @(posedge aclk) begin
		if (state == tx_desc_pkg::ds_ready)
			teng_cmd_addr <= tx_desc_pkg::local_addr_t'(in_head_idx) << tx_desc_pkg::DESC_SHIFT;
		if (state == tx_desc_pkg::ds_wait_resp && teng_rsp_valid)
			out_rs <= teng_rsp_rs;
	end

endmodule

`default_nettype wire

// File: design/host_ring_tracker.sv
`default_nettype none
`timescale 1ns/100ps

module host_ring_tracker (
	input wire aclk,
	input wire aresetn,
	input wire tx_desc_pkg::ring_len_t tdlen,
	input wire tx_desc_pkg::ring_idx_t tdt,
	input wire tdt_set,
	input wire tx_desc_pkg::thresh_t lwthresh,
	input wire host_forward,
	input wire tx_desc_pkg::ring_idx_t host_fwd_num,
	input wire wb_dequeue,
	output tx_desc_pkg::ring_idx_t host_head,
	output tx_desc_pkg::ring_idx_t host_curr,
	output tx_desc_pkg::ring_idx_t host_fresh,
	output tx_desc_pkg::ring_idx_t host_limit,
	output logic txqe_req,
	output logic txd_low_req
);

	localparam int W = $bits(tx_desc_pkg::ring_idx_t);
	localparam int LAST = tx_desc_pkg::RING_CALC_STAGES - 1;

	tx_desc_pkg::ring_idx_t ring_len;
	tx_desc_pkg::ring_idx_t host_tail;
	logic [LAST:0] calc_stage;

	// One extra bit so a sum past the ring end can be detected
	logic [W:0] head_n0, curr_n0;
	logic [W:0] pend_n0, pend_n1, fresh_n0, fresh_n1;
	tx_desc_pkg::ring_idx_t head_n1, curr_n1, pend_n2, fresh_n2;

	// tdlen counts groups of 8 descriptors
	assign ring_len = {tdlen, 3'b000};

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			calc_stage <= '0;
			head_n0 <= '0;
			curr_n0 <= '0;
			host_tail <= '0;
		end else begin
			calc_stage <= {calc_stage[LAST-1:0], tdt_set | host_forward | wb_dequeue};
			if (wb_dequeue)
				head_n0 <= {1'b0, host_head} + 1'b1;
			if (host_forward)
				curr_n0 <= {1'b0, host_curr} + {1'b0, host_fwd_num};
			if (tdt_set)
				host_tail <= tdt;
		end
	end

	// Wrap correction and modulo subtractions
	always_ff @(posedge aclk) begin
		if (calc_stage[0]) begin
			head_n1 <= (head_n0 >= {1'b0, ring_len}) ? W'(head_n0 - {1'b0, ring_len}) : W'(head_n0);
			curr_n1 <= (curr_n0 >= {1'b0, ring_len}) ? W'(curr_n0 - {1'b0, ring_len}) : W'(curr_n0);
		end
		if (calc_stage[1]) begin
			pend_n0 <= {1'b0, host_tail} + {1'b0, ring_len};
			fresh_n0 <= {1'b0, host_tail} + {1'b0, ring_len};
		end
		if (calc_stage[2]) begin
			pend_n1 <= pend_n0 - {1'b0, host_head};
			fresh_n1 <= fresh_n0 - {1'b0, host_curr};
		end
		if (calc_stage[3]) begin
			pend_n2 <= (pend_n1 >= {1'b0, ring_len}) ? W'(pend_n1 - {1'b0, ring_len}) : W'(pend_n1);
			fresh_n2 <= (fresh_n1 >= {1'b0, ring_len}) ? W'(fresh_n1 - {1'b0, ring_len}) : W'(fresh_n1);
		end
	end

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			host_head <= '0;
			host_curr <= '0;
			host_limit <= '0;
			host_fresh <= '0;
			txqe_req <= 1'b0;
			txd_low_req <= 1'b0;
		end else begin
			if (calc_stage[1]) begin
				host_head <= head_n1;
				host_curr <= curr_n1;
			end
			if (calc_stage[2])
				host_limit <= ring_len - host_curr;
			if (calc_stage[LAST])
				host_fresh <= fresh_n2;
			// Queue interrupts follow each pending update
			txqe_req <= calc_stage[LAST] && (pend_n2 == '0);
			txd_low_req <= calc_stage[LAST] && (pend_n2 < lwthresh);
		end
	end

endmodule

`default_nettype wire

// File: design/local_desc_queues.sv
`default_nettype none
`timescale 1ns/100ps

module local_desc_queues #(
	parameter int LOCAL_DESC_NUM = 256,
	localparam int IDX_W = $clog2(LOCAL_DESC_NUM)
) (
	input wire aclk,
	input wire aresetn,
	input wire in_enqueue,
	input wire tx_desc_pkg::ring_idx_t in_enq_num,
	input wire in_dequeue,
	input wire out_enqueue,
	input wire out_rs,
	input wire wb_dequeue,
	output logic [IDX_W-1:0] in_head_idx,
	output logic [IDX_W-1:0] in_tail_idx,
	output logic [IDX_W-1:0] out_head_idx,
	output logic [IDX_W:0] in_count,
	output logic [IDX_W:0] out_count,
	output logic [IDX_W:0] local_pending,
	output logic [IDX_W:0] local_available,
	output logic head_rs
);

	logic [IDX_W-1:0] out_tail_idx;
	logic [IDX_W-1:0] out_head_nxt;
	logic [IDX_W:0] enq_add;
	logic [IDX_W:0] in_deq_sub;
	logic [IDX_W:0] out_enq_add;
	logic [IDX_W:0] out_deq_sub;

	// RS bit returned by the engine, one per local slot
	logic rs_mem [LOCAL_DESC_NUM];

	assign enq_add = in_enqueue ? in_enq_num[IDX_W:0] : '0;
	assign in_deq_sub = {{IDX_W{1'b0}}, in_dequeue};
	assign out_enq_add = {{IDX_W{1'b0}}, out_enqueue};
	assign out_deq_sub = {{IDX_W{1'b0}}, wb_dequeue};
	assign out_head_nxt = wb_dequeue ? out_head_idx + 1'b1 : out_head_idx;

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			in_head_idx <= '0;
			in_tail_idx <= '0;
			in_count <= '0;
			out_head_idx <= '0;
			out_tail_idx <= '0;
			out_count <= '0;
			local_pending <= '0;
			local_available <= (IDX_W+1)'(LOCAL_DESC_NUM);
		end else begin
			// Input queue, fetched but not yet sent to the engine
			in_tail_idx <= in_tail_idx + enq_add[IDX_W-1:0];
			if (in_dequeue)
				in_head_idx <= in_head_idx + 1'b1;
			in_count <= in_count + enq_add - in_deq_sub;

			// Output queue, finished by the engine
			if (out_enqueue)
				out_tail_idx <= out_tail_idx + 1'b1;
			out_head_idx <= out_head_nxt;
			out_count <= out_count + out_enq_add - out_deq_sub;

			local_pending <= local_pending + enq_add - out_deq_sub;
			local_available <= local_available - enq_add + out_deq_sub;
		end
	end

	// Registered read at the next head, with write-through for a fresh entry
	always_ff @(posedge aclk) begin
		if (out_enqueue)
			rs_mem[out_tail_idx] <= out_rs;
		if (out_enqueue && out_tail_idx == out_head_nxt)
			head_rs <= out_rs;
		else
			head_rs <= rs_mem[out_head_nxt];
	end

endmodule

`default_nettype wire

// File: design/tx_desc_ctrl.sv
`default_nettype none
`timescale 1ns/100ps

module tx_desc_ctrl #(
	parameter int LOCAL_DESC_NUM = 256
) (
	input wire aclk,
	input wire aresetn,
	input wire en,
	input wire tx_desc_pkg::host_addr_t tdba,
	input wire tx_desc_pkg::ring_len_t tdlen,
	input wire tx_desc_pkg::ring_idx_t tdt,
	input wire tdt_set,
	input wire dpp,
	input wire tx_desc_pkg::thresh_t pthresh,
	input wire tx_desc_pkg::thresh_t hthresh,
	input wire tx_desc_pkg::thresh_t lwthresh,
	input wire idma_ready,
	input wire idma_done,
	input wire odma_ready,
	input wire odma_done,
	input wire teng_cmd_ready,
	input wire teng_rsp_valid,
	input wire teng_rsp_rs,
	output tx_desc_pkg::ring_idx_t tdh_fb,
	output wire txdw_req,
	output wire txqe_req,
	output wire txd_low_req,
	output tx_desc_pkg::host_addr_t idma_src_addr,
	output tx_desc_pkg::local_addr_t idma_dst_addr,
	output tx_desc_pkg::dma_bytes_t idma_bytes,
	output wire idma_valid,
	output tx_desc_pkg::local_addr_t odma_src_addr,
	output tx_desc_pkg::host_addr_t odma_dst_addr,
	output tx_desc_pkg::dma_bytes_t odma_bytes,
	output wire odma_valid,
	output tx_desc_pkg::local_addr_t teng_cmd_addr,
	output wire teng_cmd_valid,
	output wire teng_rsp_ready
);

	localparam int IDX_W = $clog2(LOCAL_DESC_NUM);

	// Ring tracker results
	tx_desc_pkg::ring_idx_t host_curr, host_fresh, host_limit, host_fwd_num, in_enq_num;
	wire host_forward, in_enqueue, wb_dequeue;

	// Local queue state
	wire [IDX_W-1:0] in_head_idx, in_tail_idx, out_head_idx;
	wire [IDX_W:0] in_count, out_count, local_pending, local_available;
	wire head_rs, in_dequeue, out_enqueue, out_rs;

	host_ring_tracker tracker_i (
		.aclk(aclk), .aresetn(aresetn), .tdlen(tdlen), .tdt(tdt), .tdt_set(tdt_set),
		.lwthresh(lwthresh), .host_forward(host_forward), .host_fwd_num(host_fwd_num),
		.wb_dequeue(wb_dequeue), .host_head(tdh_fb), .host_curr(host_curr),
		.host_fresh(host_fresh), .host_limit(host_limit), .txqe_req(txqe_req),
		.txd_low_req(txd_low_req)
	);

	local_desc_queues #(.LOCAL_DESC_NUM(LOCAL_DESC_NUM)) queues_i (
		.aclk(aclk), .aresetn(aresetn), .in_enqueue(in_enqueue), .in_enq_num(in_enq_num),
		.in_dequeue(in_dequeue), .out_enqueue(out_enqueue), .out_rs(out_rs),
		.wb_dequeue(wb_dequeue), .in_head_idx(in_head_idx), .in_tail_idx(in_tail_idx),
		.out_head_idx(out_head_idx), .in_count(in_count), .out_count(out_count),
		.local_pending(local_pending), .local_available(local_available), .head_rs(head_rs)
	);

	desc_dma_sequencer #(.LOCAL_DESC_NUM(LOCAL_DESC_NUM)) sequencer_i (
		.aclk(aclk), .aresetn(aresetn), .en(en), .tdba(tdba), .dpp(dpp),
		.pthresh(pthresh), .hthresh(hthresh), .host_head(tdh_fb), .host_curr(host_curr),
		.host_fresh(host_fresh), .host_limit(host_limit), .out_count(out_count),
		.local_pending(local_pending), .local_available(local_available), .head_rs(head_rs),
		.in_tail_idx(in_tail_idx), .out_head_idx(out_head_idx), .idma_ready(idma_ready),
		.idma_done(idma_done), .odma_ready(odma_ready), .odma_done(odma_done),
		.idma_src_addr(idma_src_addr), .idma_dst_addr(idma_dst_addr),
		.idma_bytes(idma_bytes), .idma_valid(idma_valid), .odma_src_addr(odma_src_addr),
		.odma_dst_addr(odma_dst_addr), .odma_bytes(odma_bytes), .odma_valid(odma_valid),
		.host_forward(host_forward), .host_fwd_num(host_fwd_num), .in_enqueue(in_enqueue),
		.in_enq_num(in_enq_num), .wb_dequeue(wb_dequeue), .txdw_req(txdw_req)
	);

	engine_dispatch #(.LOCAL_DESC_NUM(LOCAL_DESC_NUM)) dispatch_i (
		.aclk(aclk), .aresetn(aresetn), .en(en), .in_count(in_count),
		.in_head_idx(in_head_idx), .teng_cmd_ready(teng_cmd_ready),
		.teng_rsp_valid(teng_rsp_valid), .teng_rsp_rs(teng_rsp_rs),
		.teng_cmd_addr(teng_cmd_addr), .teng_cmd_valid(teng_cmd_valid),
		.teng_rsp_ready(teng_rsp_ready), .in_dequeue(in_dequeue),
		.out_enqueue(out_enqueue), .out_rs(out_rs)
	);

endmodule

`default_nettype wire

// File: design/tx_desc_pkg.sv
`default_nettype none

package tx_desc_pkg;

	// Host side widths
	typedef logic [63:0] host_addr_t;
	typedef logic [15:0] ring_idx_t;
	typedef logic [12:0] ring_len_t;

	// Local descriptor store and DMA widths
	typedef logic [15:0] local_addr_t;
	typedef logic [15:0] dma_bytes_t;
	typedef logic [5:0] thresh_t;

	// Descriptors are 16 bytes
	localparam int DESC_SHIFT = 4;
	// Status byte sits in the upper dword of a descriptor
	localparam int STA_OFFSET = 12;

	// Cycles for the ring pointers to settle after a change
	localparam int SETTLE_CYCLES = 5;
	localparam int RING_CALC_STAGES = 5;

	typedef enum logic [3:0] {
		fs_idle,
		fs_ready,
		fs_set_size,
		fs_fetch_cmd,
		fs_fetch_wait,
		fs_enqueue,
		fs_wb_cmd,
		fs_wb_wait,
		fs_dequeue,
		fs_settle
	} fetch_state_t;

	typedef enum logic [2:0] {
		ds_idle,
		ds_ready,
		ds_cmd,
		ds_dequeue,
		ds_wait_resp,
		ds_enqueue
	} dispatch_state_t;

endpackage

`default_nettype wire

// File: sim.f
design/tx_desc_pkg.sv
design/host_ring_tracker.sv
design/local_desc_queues.sv
design/desc_dma_sequencer.sv
design/engine_dispatch.sv
design/tx_desc_ctrl.sv
test/tb_clock_gen.sv
test/tx_desc_ctrl_tb.sv

// File: test/tb_clock_gen.sv
`default_nettype none
`timescale 1ns/100ps

module tb_clock_gen (
	output logic aclk,
	output logic aresetn
);

	// 100 ns period
	initial begin
		aclk = 1'b0;
		forever #50 aclk = ~aclk;
	end

	// Reset held for 4 cycles, released away from the rising edge
	initial begin
		aresetn = 1'b0;
		repeat (4) @(posedge aclk);
		@(negedge aclk);
		aresetn = 1'b1;
	end

endmodule

`default_nettype wire

// File: test/tx_desc_ctrl_tb.sv
`default_nettype none
`timescale 1ns/100ps

module tx_desc_ctrl_tb;

	localparam int LOCAL_DESC_NUM = 16;
	localparam int RING_LEN = 16;
	localparam int DESC_BYTES = 16;
	localparam int STA_BYTE = 12;
	localparam int ROUNDS = 6;
	localparam int QUIET_CYCLES = 50;

	logic aclk;
	logic aresetn;

	// DUT inputs
	logic en, tdt_set, dpp;
	tx_desc_pkg::host_addr_t tdba;
	tx_desc_pkg::ring_len_t tdlen;
	tx_desc_pkg::ring_idx_t tdt;
	tx_desc_pkg::thresh_t pthresh, hthresh, lwthresh;
	logic idma_ready, idma_done, odma_ready, odma_done;
	logic teng_cmd_ready, teng_rsp_valid, teng_rsp_rs;

	// DUT outputs
	tx_desc_pkg::ring_idx_t tdh_fb;
	logic txdw_req, txqe_req, txd_low_req;
	tx_desc_pkg::host_addr_t idma_src_addr, odma_dst_addr;
	tx_desc_pkg::local_addr_t idma_dst_addr, odma_src_addr, teng_cmd_addr;
	tx_desc_pkg::dma_bytes_t idma_bytes, odma_bytes;
	logic idma_valid, odma_valid, teng_cmd_valid, teng_rsp_ready;

	integer seed;
	int check_count, value_errors, other_errors;

	// Reference model of the ring and the local slots
	int model_tail, model_curr, fetch_slot, resp_head;
	int posted, fetched, sent, responded, rs_count, wb_count, txdw_count;
	logic [15:0] eng_q[$];
	logic [15:0] sent_q[$];
	logic rs_q[$];
	logic [15:0] slot_q[$];
	int host_q[$];
	logic txdw_expected, txqe_seen;

	// Responder handoff between the edges
	logic idma_taken, odma_taken, cmd_taken, rsp_taken;
	int idma_wait, odma_wait, rsp_wait;

	tb_clock_gen clock_i (
		.aclk(aclk),
		.aresetn(aresetn)
	);

	tx_desc_ctrl #(.LOCAL_DESC_NUM(LOCAL_DESC_NUM)) dut_i (
		.aclk(aclk), .aresetn(aresetn), .en(en), .tdba(tdba), .tdlen(tdlen), .tdt(tdt),
		.tdt_set(tdt_set), .dpp(dpp), .pthresh(pthresh), .hthresh(hthresh),
		.lwthresh(lwthresh), .idma_ready(idma_ready), .idma_done(idma_done),
		.odma_ready(odma_ready), .odma_done(odma_done), .teng_cmd_ready(teng_cmd_ready),
		.teng_rsp_valid(teng_rsp_valid), .teng_rsp_rs(teng_rsp_rs), .tdh_fb(tdh_fb),
		.txdw_req(txdw_req), .txqe_req(txqe_req), .txd_low_req(txd_low_req),
		.idma_src_addr(idma_src_addr), .idma_dst_addr(idma_dst_addr),
		.idma_bytes(idma_bytes), .idma_valid(idma_valid), .odma_src_addr(odma_src_addr),
		.odma_dst_addr(odma_dst_addr), .odma_bytes(odma_bytes), .odma_valid(odma_valid),
		.teng_cmd_addr(teng_cmd_addr), .teng_cmd_valid(teng_cmd_valid),
		.teng_rsp_ready(teng_rsp_ready)
	);

	task automatic compare_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		check_count++;
		assert (got === exp) else begin
			value_errors++;
			$display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic require_true(input logic cond, input string what);
		check_count++;
		assert (cond) else begin
			other_errors++;
			$display("Failure at %0t ns: %s", $time, what);
		end
	endtask

	task automatic expect_outputs_idle();
		compare_value("idma_valid", idma_valid, 0);
		compare_value("odma_valid", odma_valid, 0);
		compare_value("teng_cmd_valid", teng_cmd_valid, 0);
		compare_value("teng_rsp_ready", teng_rsp_ready, 0);
		compare_value("txdw_req", txdw_req, 0);
		compare_value("txqe_req", txqe_req, 0);
		compare_value("txd_low_req", txd_low_req, 0);
	endtask

	// Fetch must start at the current host index and stay inside the ring
	task automatic model_fetch();
		int n;
		int fresh;
		int i;
		n = int'(idma_bytes) / DESC_BYTES;
		fresh = (model_tail - model_curr + RING_LEN) % RING_LEN;
		compare_value("idma_src_addr", idma_src_addr, tdba + 64'(model_curr * DESC_BYTES));
		compare_value("idma_dst_addr", idma_dst_addr, 64'(fetch_slot * DESC_BYTES));
		compare_value("idma_bytes[3:0]", idma_bytes[3:0], 0);
		require_true(n >= 1, "fetch command for zero descriptors");
		require_true(n <= RING_LEN - model_curr, "fetch runs past the end of the ring");
		require_true(n <= fresh, "fetch reaches beyond the ring tail");
		if (dpp)
			compare_value("idma descriptor count with dpp", n, 1);
		for (i = 0; i < n && i < RING_LEN; i++) begin
			eng_q.push_back(16'(fetch_slot * DESC_BYTES));
			fetch_slot = (fetch_slot + 1) % LOCAL_DESC_NUM;
		end
		model_curr = (model_curr + n) % RING_LEN;
		fetched += n;
	endtask

	task automatic expect_engine_cmd();
		logic [15:0] exp_addr;
		require_true(eng_q.size() != 0, "engine command with no fetched descriptor waiting");
		if (eng_q.size() != 0) begin
			exp_addr = eng_q.pop_front();
			compare_value("teng_cmd_addr", teng_cmd_addr, exp_addr);
			sent_q.push_back(exp_addr);
		end
		sent++;
	endtask

	task automatic note_response();
		logic [15:0] addr;
		addr = '0;
		require_true(sent_q.size() != 0, "engine response with no command outstanding");
		if (sent_q.size() != 0)
			addr = sent_q.pop_front();
		rs_q.push_back(teng_rsp_rs);
		slot_q.push_back(addr);
		host_q.push_back(resp_head);
		resp_head = (resp_head + 1) % RING_LEN;
		responded++;
		if (teng_rsp_rs)
			rs_count++;
	endtask

	// Completions without RS were dequeued directly and the next RS one owns this write-back
	task automatic verify_writeback();
		logic [15:0] slot;
		int host;
		while (rs_q.size() != 0 && rs_q[0] == 1'b0) begin
			void'(rs_q.pop_front());
			void'(slot_q.pop_front());
			void'(host_q.pop_front());
		end
		require_true(rs_q.size() != 0, "write-back with no RS response pending");
		if (rs_q.size() != 0) begin
			void'(rs_q.pop_front());
			slot = slot_q.pop_front();
			host = host_q.pop_front();
			compare_value("odma_src_addr", odma_src_addr, 64'(slot) + STA_BYTE);
			compare_value("odma_dst_addr", odma_dst_addr,
				tdba + 64'(host * DESC_BYTES) + STA_BYTE);
			compare_value("odma_bytes", odma_bytes, 1);
		end
		wb_count++;
	endtask

	// Called on a falling edge
	task automatic post_descriptors(input int amount);
		model_tail = (model_tail + amount) % RING_LEN;
		posted += amount;
		tdt = 16'(model_tail);
		tdt_set = 1'b1;
		txqe_seen = 1'b0;
		@(negedge aclk);
		tdt_set = 1'b0;
	endtask

	task automatic wait_for_quiet();
		int quiet;
		quiet = 0;
		while (quiet < QUIET_CYCLES) begin
			@(posedge aclk);
			if (idma_valid || odma_valid || teng_cmd_valid || teng_rsp_valid
				|| idma_wait != 0 || odma_wait != 0 || rsp_wait != 0 || responded != posted)
				quiet = 0;
			else
				quiet++;
		end
	endtask

	task automatic close_round();
		logic rs_bit;
		compare_value("tdh_fb", tdh_fb, model_tail);
		require_true(txqe_seen, "no txqe_req pulse since the last tdt_set");
		compare_value("descriptors fetched", fetched, posted);
		compare_value("engine commands", sent, posted);
		compare_value("write-backs", wb_count, rs_count);
		compare_value("txdw_req pulses", txdw_count, rs_count);
		// Whatever is left was dequeued without a write-back
		while (rs_q.size() != 0) begin
			rs_bit = rs_q.pop_front();
			require_true(rs_bit == 1'b0, "RS response never written back");
			void'(slot_q.pop_front());
			void'(host_q.pop_front());
		end
	endtask

	task automatic finish_run();
		$display("Checks %0d, value errors %0d, other errors %0d",
			check_count, value_errors, other_errors);
		if (value_errors + other_errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	endtask

	// Handshakes and pulses seen at the rising edge
	always @(posedge aclk) begin
		if (aresetn) begin
			if (txdw_expected)
				compare_value("txdw_req", txdw_req, 1);
			txdw_expected = odma_done;
			if (txdw_req)
				txdw_count++;
			if (txqe_req) begin
				txqe_seen = 1'b1;
				// Pending is zero here so it sits below any nonzero low-water mark
				compare_value("txd_low_req", txd_low_req, lwthresh != '0);
			end
			if (txd_low_req)
				require_true(lwthresh != '0, "txd_low_req with a zero low-water mark");
			if (idma_valid && idma_ready) begin
				model_fetch();
				idma_taken = 1'b1;
			end
			if (teng_cmd_valid && teng_cmd_ready) begin
				expect_engine_cmd();
				cmd_taken = 1'b1;
			end
			if (teng_rsp_valid && teng_rsp_ready) begin
				note_response();
				rsp_taken = 1'b1;
			end
			if (odma_valid && odma_ready) begin
				verify_writeback();
				odma_taken = 1'b1;
			end
		end
	end

	// DMA and engine responders
	always @(negedge aclk) begin
		if (aresetn) begin
			idma_ready = ($random(seed) & 3) != 0;
			odma_ready = ($random(seed) & 3) != 0;
			teng_cmd_ready = ($random(seed) & 1) != 0;
			idma_done = 1'b0;
			odma_done = 1'b0;
			if (idma_taken) begin
				idma_wait = 1 + {$random(seed)} % 6;
				idma_taken = 1'b0;
			end
			if (idma_wait != 0) begin
				idma_wait--;
				idma_done = (idma_wait == 0);
			end
			if (odma_taken) begin
				odma_wait = 1 + {$random(seed)} % 6;
				odma_taken = 1'b0;
			end
			if (odma_wait != 0) begin
				odma_wait--;
				odma_done = (odma_wait == 0);
			end
			if (rsp_taken) begin
				teng_rsp_valid = 1'b0;
				rsp_taken = 1'b0;
			end
			if (cmd_taken) begin
				rsp_wait = 1 + {$random(seed)} % 8;
				cmd_taken = 1'b0;
			end
			if (rsp_wait != 0) begin
				rsp_wait--;
				if (rsp_wait == 0) begin
					teng_rsp_valid = 1'b1;
					teng_rsp_rs = 1'($random(seed));
				end
			end
		end
	end

	initial begin : stimulus
		int round;
		int first_amt;
		int second_amt;
		int gap;
		logic next_dpp;
		seed = 32'hcdab_f303;
		check_count = 0;
		value_errors = 0;
		other_errors = 0;
		{model_tail, model_curr, fetch_slot, resp_head} = '0;
		{posted, fetched, sent, responded, rs_count, wb_count, txdw_count} = '0;
		{txdw_expected, txqe_seen, idma_taken, odma_taken, cmd_taken, rsp_taken} = '0;
		{idma_wait, odma_wait, rsp_wait} = '0;
		en = 1'b0;
		tdt_set = 1'b0;
		dpp = 1'b0;
		tdt = '0;
		tdlen = 13'd2;
		tdba = {$random(seed), $random(seed)};
		tdba[3:0] = 4'h0;
		pthresh = 6'($random(seed) & 7);
		hthresh = 6'($random(seed) & 3);
		lwthresh = 6'(1 + ($random(seed) & 15));
		{idma_ready, idma_done, odma_ready, odma_done} = '0;
		{teng_cmd_ready, teng_rsp_valid, teng_rsp_rs} = '0;

		wait (aresetn === 1'b1);
		repeat (8) begin
			@(posedge aclk);
			expect_outputs_idle();
		end
		@(negedge aclk);
		en = 1'b1;

		// Two tail bumps per round that together stay below the ring size
		for (round = 0; round < ROUNDS; round++) begin
			@(posedge aclk);
			next_dpp = 1'($random(seed));
			first_amt = 1 + {$random(seed)} % 10;
			second_amt = 1 + {$random(seed)} % (RING_LEN - 1 - first_amt);
			gap = {$random(seed)} % 40;
			@(negedge aclk);
			dpp = next_dpp;
			post_descriptors(first_amt);
			repeat (gap) @(negedge aclk);
			post_descriptors(second_amt);
			wait_for_quiet();
			close_round();
		end
		finish_run();
	end

	// Limit grows with the descriptors posted so far
	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles <= 400 * posted + 2000) begin
			@(posedge aclk);
			cycles++;
		end
		other_errors++;
		$display("Watchdog expired after %0d cycles, %0d of %0d descriptors answered",
			cycles, responded, posted);
		finish_run();
	end

endmodule

`default_nettype wire
